//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

        typedef logic [13:0] csr_num_t;
        typedef logic [31:0] csr_word_t;
        typedef logic [1:0]  plv_t;

        // csr numbers
        localparam csr_num_t CSR_CRMD   = 14'h0;
        localparam csr_num_t CSR_PRMD   = 14'h1;
        localparam csr_num_t CSR_ECFG   = 14'h4;
        localparam csr_num_t CSR_ESTAT  = 14'h5;
        localparam csr_num_t CSR_ERA    = 14'h6;
        localparam csr_num_t CSR_BADV   = 14'h7;
        localparam csr_num_t CSR_EENTRY = 14'hc;
        localparam csr_num_t CSR_SAVE0  = 14'h30;
        localparam csr_num_t CSR_TID    = 14'h40;
        localparam csr_num_t CSR_TCFG   = 14'h41;
        localparam csr_num_t CSR_TVAL   = 14'h42;
        localparam csr_num_t CSR_TICLR  = 14'h44;

        localparam logic [5:0] ECODE_ADE     = 6'h8;
        localparam logic [5:0] ECODE_ALE     = 6'h9;
        localparam logic [8:0] ESUBCODE_ADEF = 9'h0;

        // one-hot write select positions of the writable csrs
        localparam int SEL_CRMD   = 0;
        localparam int SEL_PRMD   = 1;
        localparam int SEL_ECFG   = 2;
        localparam int SEL_ESTAT  = 3;
        localparam int SEL_ERA    = 4;
        localparam int SEL_BADV   = 5;
        localparam int SEL_EENTRY = 6;
        localparam int SEL_TID    = 7;
        localparam int SEL_TCFG   = 8;
        localparam int SEL_TICLR  = 9;
        localparam int SEL_SAVE0  = 10;
        localparam int MAX_SAVE   = 8;
        localparam int NUM_SEL    = SEL_SAVE0 + MAX_SAVE;

        typedef struct packed {
                logic [NUM_SEL-1:0] sel;
                csr_word_t          wmask;
                csr_word_t          wvalue;
        } csr_wr_t;

        typedef struct packed {
                logic ie;
                plv_t plv;
        } crmd_t;

        typedef struct packed {
                logic pie;
                plv_t pplv;
        } prmd_t;

        // same layout as the TCFG word
        typedef struct packed {
                logic [29:0] initval;
                logic        periodic;
                logic        en;
        } tcfg_t;

        typedef struct packed {
                logic        ex;
                logic        ertn;
                logic [5:0]  ecode;
                logic [8:0]  esubcode;
                csr_word_t   pc;
                csr_word_t   vaddr;
        } ex_info_t;

        function automatic csr_word_t masked_merge(input csr_word_t old_value,
                                                   input csr_word_t wmask,
                                                   input csr_word_t wvalue);
                return (wmask & wvalue) | (~wmask & old_value);
        endfunction

endpackage

`default_nettype wire

//--- rtl/csr_access_port.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_port
        import csr_pkg::*;
#(
        parameter int SAVE_COUNT = 4
) (
        input  csr_num_t  csr_num,
        input  logic      csr_we,
        input  csr_word_t csr_wmask,
        input  csr_word_t csr_wvalue,
        output csr_wr_t   wr,

        input  csr_word_t crmd_rd,
        input  csr_word_t prmd_rd,
        input  csr_word_t ecfg_rd,
        input  csr_word_t estat_is_rd,
        input  csr_word_t estat_code_rd,
        input  csr_word_t era_rd,
        input  csr_word_t badv_rd,
        input  csr_word_t eentry_rd,
        input  csr_word_t save_rd [SAVE_COUNT],
        input  csr_word_t tid_rd,
        input  csr_word_t tcfg_rd,
        input  csr_word_t tval_rd,
        output csr_word_t csr_rvalue
);

        logic [NUM_SEL-1:0] hit;
        logic               tval_hit;

        // one compare per register
        always_comb begin
                hit = '0;
                hit[SEL_CRMD]   = csr_num == CSR_CRMD;
                hit[SEL_PRMD]   = csr_num == CSR_PRMD;
                hit[SEL_ECFG]   = csr_num == CSR_ECFG;
                hit[SEL_ESTAT]  = csr_num == CSR_ESTAT;
                hit[SEL_ERA]    = csr_num == CSR_ERA;
                hit[SEL_BADV]   = csr_num == CSR_BADV;
                hit[SEL_EENTRY] = csr_num == CSR_EENTRY;
                hit[SEL_TID]    = csr_num == CSR_TID;
                hit[SEL_TCFG]   = csr_num == CSR_TCFG;
                hit[SEL_TICLR]  = csr_num == CSR_TICLR;
                for (int i = 0; i < SAVE_COUNT; i++) begin
                        hit[SEL_SAVE0+i] = csr_num == CSR_SAVE0 + csr_num_t'(i);
                end
        end

        assign tval_hit = csr_num == CSR_TVAL;

        assign wr.sel    = hit & {NUM_SEL{csr_we}};
        assign wr.wmask  = csr_wmask;
        assign wr.wvalue = csr_wvalue;

        // and-or read mux
        // unknown numbers and ticlr read as 0
        always_comb begin
                csr_rvalue = '0;
                if (hit[SEL_CRMD])   csr_rvalue |= crmd_rd;
                if (hit[SEL_PRMD])   csr_rvalue |= prmd_rd;
                if (hit[SEL_ECFG])   csr_rvalue |= ecfg_rd;
                if (hit[SEL_ESTAT])  csr_rvalue |= estat_is_rd | estat_code_rd;
                if (hit[SEL_ERA])    csr_rvalue |= era_rd;
                if (hit[SEL_BADV])   csr_rvalue |= badv_rd;
                if (hit[SEL_EENTRY]) csr_rvalue |= eentry_rd;
                if (hit[SEL_TID])    csr_rvalue |= tid_rd;
                if (hit[SEL_TCFG])   csr_rvalue |= tcfg_rd;
                if (tval_hit)        csr_rvalue |= tval_rd;
                for (int i = 0; i < SAVE_COUNT; i++) begin
                        if (hit[SEL_SAVE0+i]) csr_rvalue |= save_rd[i];
                end
        end

endmodule

`default_nettype wire

//--- rtl/exception_state.sv
`timescale 1ns/1ps
`default_nettype none

module exception_state
        import csr_pkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  csr_wr_t   wr,
        input  ex_info_t  exc,
        output csr_word_t crmd_rd,
        output csr_word_t prmd_rd,
        output csr_word_t estat_code_rd,
        output csr_word_t era_rd,
        output csr_word_t eentry_rd,
        output csr_word_t badv_rd,
        output logic      crmd_ie,
        output csr_word_t ex_entry,
        output csr_word_t ertn_pc
);

        crmd_t       crmd;
        prmd_t       prmd;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        csr_word_t   era;
        logic [25:0] eentry_va;
        csr_word_t   badv;
        csr_word_t   crmd_new;
        csr_word_t   prmd_new;
        csr_word_t   eentry_new;
        logic        addr_err;

        assign crmd_new   = masked_merge(crmd_rd, wr.wmask, wr.wvalue);
        assign prmd_new   = masked_merge(prmd_rd, wr.wmask, wr.wvalue);
        assign eentry_new = masked_merge(eentry_rd, wr.wmask, wr.wvalue);
        assign addr_err   = exc.ecode == ECODE_ADE || exc.ecode == ECODE_ALE;

        always_ff @(posedge clk) begin
                if (reset) begin
                        crmd <= '0;
                end else if (exc.ex) begin
                        // enter at plv0 with interrupts off
                        crmd.plv <= 2'b00;
                        crmd.ie  <= 1'b0;
                end else if (exc.ertn) begin
                        crmd.plv <= prmd.pplv;
                        crmd.ie  <= prmd.pie;
                end else if (wr.sel[SEL_CRMD]) begin
                        crmd <= crmd_t'(crmd_new[2:0]);
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        prmd <= '0;
                end else if (exc.ex) begin
                        prmd.pplv <= crmd.plv;
                        prmd.pie  <= crmd.ie;
                end else if (wr.sel[SEL_PRMD]) begin
                        prmd <= prmd_t'(prmd_new[2:0]);
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        ecode    <= '0;
                        esubcode <= '0;
                        era      <= '0;
                end else if (exc.ex) begin
                        ecode    <= exc.ecode;
                        esubcode <= exc.esubcode;
                        era      <= exc.pc;
                end else if (wr.sel[SEL_ERA]) begin
                        era <= masked_merge(era, wr.wmask, wr.wvalue);
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        eentry_va <= '0;
                end else if (wr.sel[SEL_EENTRY]) begin
                        eentry_va <= eentry_new[31:6];
                end
        end

        // fetch errors report the pc and other address errors the data address
        always_ff @(posedge clk) begin
                if (reset) begin
                        badv <= '0;
                end else if (exc.ex && addr_err) begin
                        if (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
                                badv <= exc.pc;
                        else
                                badv <= exc.vaddr;
                end else if (wr.sel[SEL_BADV]) begin
                        badv <= masked_merge(badv, wr.wmask, wr.wvalue);
                end
        end

        assign crmd_rd       = {29'b0, crmd};
        assign prmd_rd       = {29'b0, prmd};
        assign estat_code_rd = {1'b0, esubcode, ecode, 16'b0};
        assign era_rd        = era;
        assign eentry_rd     = {eentry_va, 6'b0};
        assign badv_rd       = badv;

        assign crmd_ie  = crmd.ie;
        assign ex_entry = eentry_rd;
        assign ertn_pc  = era;

endmodule

`default_nettype wire

//--- rtl/software_regs.sv
`timescale 1ns/1ps
`default_nettype none

module software_regs
        import csr_pkg::*;
#(
        parameter int        SAVE_COUNT = 4,
        parameter csr_word_t CORE_ID    = '0
) (
        input  logic      clk,
        input  logic      reset,
        input  csr_wr_t   wr,
        output csr_word_t save_rd [SAVE_COUNT],
        output csr_word_t tid_rd
);

        // scratch words for the exception handler
        always_ff @(posedge clk) begin
                for (int i = 0; i < SAVE_COUNT; i++) begin
                        if (reset)
                                save_rd[i] <= '0;
                        else if (wr.sel[SEL_SAVE0+i])
                                save_rd[i] <= masked_merge(save_rd[i], wr.wmask, wr.wvalue);
                end
        end

        always_ff @(posedge clk) begin
                if (reset)
                        tid_rd <= CORE_ID;
                else if (wr.sel[SEL_TID])
                        tid_rd <= masked_merge(tid_rd, wr.wmask, wr.wvalue);
        end

endmodule

`default_nettype wire

//--- rtl/timer_unit.sv
`timescale 1ns/1ps
`default_nettype none

module timer_unit
        import csr_pkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  csr_wr_t   wr,
        output csr_word_t tcfg_rd,
        output csr_word_t tval_rd,
        output logic      timer_pending
);

        tcfg_t     tcfg;
        tcfg_t     tcfg_new;
        csr_word_t tval;
        logic      tval_zero;
        logic      ticlr_hit;

        assign tcfg_new  = masked_merge(tcfg, wr.wmask, wr.wvalue);
        assign tval_zero = tval == '0;
        assign ticlr_hit = wr.sel[SEL_TICLR] && wr.wmask[0] && wr.wvalue[0];

        always_ff @(posedge clk) begin
                if (reset)
                        tcfg <= '0;
                else if (wr.sel[SEL_TCFG])
                        tcfg <= tcfg_new;
        end

        // all ones means stopped
        always_ff @(posedge clk) begin
                if (reset) begin
                        tval <= '1;
                end else if (wr.sel[SEL_TCFG] && tcfg_new.en) begin
                        tval <= {tcfg_new.initval, 2'b00};
                end else if (tcfg.en && tval != '1) begin
                        if (!tval_zero)
                                tval <= tval - 32'd1;
                        else if (tcfg.periodic)
                                tval <= {tcfg.initval, 2'b00};
                        else
                                tval <= '1;
                end
        end

        // expiry wins over a clear in the same cycle
        always_ff @(posedge clk) begin
                if (reset)
                        timer_pending <= 1'b0;
                else if (tval_zero)
                        timer_pending <= 1'b1;
                else if (ticlr_hit)
                        timer_pending <= 1'b0;
        end

        assign tcfg_rd = tcfg;
        assign tval_rd = tval;

endmodule

`default_nettype wire

//--- rtl/interrupt_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl
        import csr_pkg::*;
(
        input  logic       clk,
        input  logic       reset,
        input  csr_wr_t    wr,
        input  logic [7:0] hw_int,
        input  logic       ipi_int,
        input  logic       timer_pending,
        input  logic       crmd_ie,
        output csr_word_t  estat_is_rd,
        output csr_word_t  ecfg_rd,
        output logic       csru_int
);

        // lie bit 10 is reserved
        localparam logic [12:0] LIE_MASK = 13'h1bff;

        logic [1:0]  swi;
        logic [7:0]  hwi;
        logic        ipi;
        logic [12:0] lie;
        logic [12:0] is_bits;
        csr_word_t   is_new;
        csr_word_t   ecfg_new;

        assign is_bits  = {ipi, timer_pending, 1'b0, hwi, swi};
        assign is_new   = masked_merge(estat_is_rd, wr.wmask, wr.wvalue);
        assign ecfg_new = masked_merge(ecfg_rd, wr.wmask, wr.wvalue);

        always_ff @(posedge clk) begin
                if (reset) begin
                        swi <= '0;
                        hwi <= '0;
                        ipi <= 1'b0;
                end else begin
                        hwi <= hw_int;
                        ipi <= ipi_int;
                        if (wr.sel[SEL_ESTAT])
                                swi <= is_new[1:0];
                end
        end

        always_ff @(posedge clk) begin
                if (reset)
                        lie <= '0;
                else if (wr.sel[SEL_ECFG])
                        lie <= ecfg_new[12:0] & LIE_MASK;
        end

        assign estat_is_rd = {19'b0, is_bits};
        assign ecfg_rd     = {19'b0, lie};

        // ipi sits in bit 12 and stays out of the request
        assign csru_int = (|(is_bits[11:0] & lie[11:0])) & crmd_ie;

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit
        import csr_pkg::*;
#(
        parameter int        SAVE_COUNT = 4,
        parameter csr_word_t CORE_ID    = '0
) (
        input  logic       clk,
        input  logic       reset,
        input  csr_num_t   csr_num,
        input  logic       csr_we,
        input  csr_word_t  csr_wmask,
        input  csr_word_t  csr_wvalue,
        output csr_word_t  csr_rvalue,
        input  logic       wb_ex,
        input  logic       ertn_flush,
        input  logic [5:0] wb_ecode,
        input  logic [8:0] wb_esubcode,
        input  csr_word_t  wb_pc,
        input  csr_word_t  wb_vaddr,
        input  logic [7:0] hw_int,
        input  logic       ipi_int,
        output csr_word_t  ex_entry,
        output csr_word_t  ertn_pc,
        output csr_word_t  wb_tid,
        output logic       csru_int
);

        csr_wr_t   wr;
        ex_info_t  exc;
        csr_word_t crmd_rd, prmd_rd, ecfg_rd, estat_is_rd, estat_code_rd;
        csr_word_t era_rd, badv_rd, eentry_rd, tid_rd, tcfg_rd, tval_rd;
        csr_word_t save_rd [SAVE_COUNT];
        logic      crmd_ie;
        logic      timer_pending;

        assign exc = '{ex: wb_ex, ertn: ertn_flush, ecode: wb_ecode,
                       esubcode: wb_esubcode, pc: wb_pc, vaddr: wb_vaddr};
        assign wb_tid = tid_rd;

        csr_access_port #(.SAVE_COUNT(SAVE_COUNT)) port0 (
                .csr_num, .csr_we, .csr_wmask, .csr_wvalue, .wr,
                .crmd_rd, .prmd_rd, .ecfg_rd, .estat_is_rd, .estat_code_rd,
                .era_rd, .badv_rd, .eentry_rd, .save_rd, .tid_rd, .tcfg_rd,
                .tval_rd, .csr_rvalue
        );

        exception_state exc0 (
                .clk, .reset, .wr, .exc, .crmd_rd, .prmd_rd, .estat_code_rd,
                .era_rd, .eentry_rd, .badv_rd, .crmd_ie, .ex_entry, .ertn_pc
        );

        software_regs #(.SAVE_COUNT(SAVE_COUNT), .CORE_ID(CORE_ID)) sw0 (
                .clk, .reset, .wr, .save_rd, .tid_rd
        );

        timer_unit timer0 (
                .clk, .reset, .wr, .tcfg_rd, .tval_rd, .timer_pending
        );

        interrupt_ctrl intc0 (
                .clk, .reset, .wr, .hw_int, .ipi_int, .timer_pending, .crmd_ie,
                .estat_is_rd, .ecfg_rd, .csru_int
        );

endmodule

`default_nettype wire

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
        import csr_pkg::*;
();

        localparam int        SAVE_COUNT  = 4;
        localparam csr_word_t CORE_ID     = 32'h0000_0003;
        localparam int        TEST_CYCLES = 500;
        localparam int        MARGIN      = 200;

        logic       clk;
        logic       reset;
        csr_num_t   csr_num;
        logic       csr_we;
        csr_word_t  csr_wmask;
        csr_word_t  csr_wvalue;
        csr_word_t  csr_rvalue;
        logic       wb_ex;
        logic       ertn_flush;
        logic [5:0] wb_ecode;
        logic [8:0] wb_esubcode;
        csr_word_t  wb_pc;
        csr_word_t  wb_vaddr;
        logic [7:0] hw_int;
        logic       ipi_int;
        csr_word_t  ex_entry;
        csr_word_t  ertn_pc;
        csr_word_t  wb_tid;
        logic       csru_int;

        csr_word_t model [16384];
        csr_word_t seed = 32'hbb06;
        int        checks = 0;
        int        errors = 0;

        csr_num_t kept [15] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                CSR_EENTRY, CSR_SAVE0, CSR_SAVE0 + 14'd1, CSR_SAVE0 + 14'd2,
                                CSR_SAVE0 + 14'd3, CSR_TID, CSR_TCFG, CSR_TVAL, CSR_TICLR};
        csr_num_t unknown [5] = '{14'h2, 14'h8, 14'h34, 14'h43, 14'h1000};
        csr_num_t exc_regs [6] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                   CSR_EENTRY};

        csr_unit #(.SAVE_COUNT(SAVE_COUNT), .CORE_ID(CORE_ID)) dut0 (
                .clk, .reset, .csr_num, .csr_we, .csr_wmask, .csr_wvalue, .csr_rvalue,
                .wb_ex, .ertn_flush, .wb_ecode, .wb_esubcode, .wb_pc, .wb_vaddr,
                .hw_int, .ipi_int, .ex_entry, .ertn_pc, .wb_tid, .csru_int
        );

        always #2 clk = ~clk;

        function automatic csr_word_t rnd();
                seed = seed * 32'd1664525 + 32'd1013904223;
                return seed;
        endfunction

        // bits that software can change in each csr
        function automatic csr_word_t writable(input csr_num_t num);
                if (num >= CSR_SAVE0 && num < CSR_SAVE0 + SAVE_COUNT)
                        return '1;
                case (num)
                        CSR_CRMD, CSR_PRMD: return 32'h7;
                        CSR_ECFG: return 32'h1bff;
                        CSR_ESTAT: return 32'h3;
                        CSR_EENTRY: return 32'hffff_ffc0;
                        CSR_ERA, CSR_BADV, CSR_TID, CSR_TCFG: return '1;
                        default: return '0;
                endcase
        endfunction

        function automatic logic want_int();
                return (|(model[CSR_ESTAT][11:0] & model[CSR_ECFG][11:0])) & model[CSR_CRMD][2];
        endfunction

        task automatic expect_eq(input csr_word_t got, input csr_word_t exp, input string what);
                checks++;
                assert (got === exp) else begin
                        $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
                        errors++;
                end
        endtask

        task automatic read_check(input csr_num_t num, input csr_word_t exp, input string what);
                @(posedge clk);
                csr_num <= num;
                @(negedge clk);
                expect_eq(csr_rvalue, exp, what);
        endtask

        task automatic write_check(input csr_num_t num, input csr_word_t mask,
                                   input csr_word_t value);
                csr_word_t keep;
                keep = mask & writable(num);
                @(posedge clk);
                csr_num <= num;
                csr_we <= 1'b1;
                csr_wmask <= mask;
                csr_wvalue <= value;
                @(posedge clk);
                csr_we <= 1'b0;
                model[num] = (model[num] & ~keep) | (value & keep);
                @(negedge clk);
                expect_eq(csr_rvalue, model[num], "write read-back");
                if (num == CSR_TID)
                        expect_eq(wb_tid, model[num], "wb_tid after write");
        endtask

        task automatic take_exception(input logic [5:0] code, input logic [8:0] sub,
                                      input csr_word_t pc, input csr_word_t vaddr);
                @(posedge clk);
                wb_ex <= 1'b1;
                wb_ecode <= code;
                wb_esubcode <= sub;
                wb_pc <= pc;
                wb_vaddr <= vaddr;
                @(posedge clk);
                wb_ex <= 1'b0;
                model[CSR_PRMD] = model[CSR_CRMD];
                model[CSR_CRMD] = '0;
                model[CSR_ESTAT] = {1'b0, sub, code, 16'h0} | (model[CSR_ESTAT] & 32'h1fff);
                model[CSR_ERA] = pc;
                if (code == ECODE_ADE && sub == ESUBCODE_ADEF)
                        model[CSR_BADV] = pc;
                else if (code == ECODE_ADE || code == ECODE_ALE)
                        model[CSR_BADV] = vaddr;
                @(negedge clk);
                expect_eq(ex_entry, model[CSR_EENTRY], "ex_entry");
                foreach (exc_regs[i])
                        read_check(exc_regs[i], model[exc_regs[i]], "exception state");
        endtask

        initial begin
                #((TEST_CYCLES + MARGIN) * 4);
                $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
                $display("Simulation FAILED");
                $finish;
        end

        initial begin
                csr_word_t v;
                csr_word_t r;
                clk = 1'b0;
                reset = 1'b1;
                csr_num = '0;
                csr_we = 1'b0;
                csr_wmask = '0;
                csr_wvalue = '0;
                wb_ex = 1'b0;
                ertn_flush = 1'b0;
                wb_ecode = '0;
                wb_esubcode = '0;
                wb_pc = '0;
                wb_vaddr = '0;
                hw_int = '0;
                ipi_int = 1'b0;
                foreach (model[i])
                        model[i] = '0;
                model[CSR_TID] = CORE_ID;
                model[CSR_TVAL] = '1;
                repeat (4) @(posedge clk);
                reset <= 1'b0;

                // reset values then masked writes
                foreach (kept[i])
                        read_check(kept[i], model[kept[i]], "reset value");
                expect_eq(wb_tid, CORE_ID, "wb_tid");
                foreach (kept[i]) begin
                        for (int n = 0; n < 4; n++) begin
                                v = rnd();
                                // keep the timer stopped here
                                if (kept[i] == CSR_TCFG)
                                        v[0] = 1'b0;
                                write_check(kept[i], rnd(), v);
                        end
                end
                foreach (unknown[i])
                        write_check(unknown[i], '1, rnd());

                // exception entry and return
                write_check(CSR_CRMD, '1, 32'h7);
                write_check(CSR_EENTRY, '1, 32'h1c00_8040);
                take_exception(ECODE_ALE, 9'h0, 32'h1c00_0100, 32'h0000_1234);
                take_exception(ECODE_ADE, ESUBCODE_ADEF, 32'h1c00_0204, 32'h0bad_0000);
                take_exception(6'hb, 9'h1, 32'h1c00_0300, 32'h0000_5678);
                write_check(CSR_PRMD, '1, 32'h6);
                @(posedge clk);
                ertn_flush <= 1'b1;
                @(posedge clk);
                ertn_flush <= 1'b0;
                model[CSR_CRMD] = model[CSR_PRMD];
                @(negedge clk);
                expect_eq(ertn_pc, model[CSR_ERA], "ertn_pc");
                read_check(CSR_CRMD, model[CSR_CRMD], "crmd after ertn");

                // one-shot timer with initval 5 loading 20
                write_check(CSR_CRMD, '1, 32'h4);
                write_check(CSR_ECFG, '1, 32'h800);
                write_check(CSR_TCFG, '1, 32'h15);
                for (int k = 1; k <= 22; k++) begin
                        read_check(CSR_TVAL, (k <= 20) ? csr_word_t'(20 - k) : 32'hffff_ffff,
                                   "one-shot tval");
                        expect_eq(32'(csru_int), 32'(k > 20), "timer interrupt");
                end
                model[CSR_ESTAT] |= 32'h800;
                read_check(CSR_ESTAT, model[CSR_ESTAT], "estat timer bit set");
                write_check(CSR_TICLR, 32'h1, 32'h1);
                model[CSR_ESTAT] &= ~32'h800;
                read_check(CSR_ESTAT, model[CSR_ESTAT], "estat timer bit cleared");

                // periodic timer with initval 3 loading 12
                write_check(CSR_TCFG, '1, 32'hf);
                for (int k = 1; k <= 30; k++) begin
                        read_check(CSR_TVAL, csr_word_t'(12 - (k % 13)), "periodic tval");
                        expect_eq(32'(csru_int), 32'(k >= 13), "periodic interrupt");
                end
                write_check(CSR_TCFG, '1, 32'hc);
                repeat (3) read_check(CSR_TVAL, 32'd6, "stopped tval");
                model[CSR_TVAL] = 32'd6;
                model[CSR_ESTAT] |= 32'h800;

                // interrupt request over random combinations
                for (int n = 0; n < 24; n++) begin
                        if (n == 12) begin
                                write_check(CSR_TICLR, 32'h1, 32'h1);
                                model[CSR_ESTAT] &= ~32'h800;
                        end
                        write_check(CSR_ECFG, '1, rnd());
                        write_check(CSR_CRMD, '1, rnd());
                        write_check(CSR_ESTAT, 32'h3, rnd());
                        r = rnd();
                        @(posedge clk);
                        hw_int <= r[7:0];
                        ipi_int <= r[8];
                        csr_num <= CSR_ESTAT;
                        @(negedge clk);
                        expect_eq(csr_rvalue, model[CSR_ESTAT], "estat before hw sample");
                        expect_eq(32'(csru_int), 32'(want_int()), "interrupt before hw sample");
                        model[CSR_ESTAT] = (model[CSR_ESTAT] & ~32'h13fc)
                                           | {19'b0, r[8], 2'b0, r[7:0], 2'b0};
                        read_check(CSR_ESTAT, model[CSR_ESTAT], "estat with hw_int");
                        expect_eq(32'(csru_int), 32'(want_int()), "interrupt request");
                end

                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- vlog.f
rtl/csr_pkg.sv
rtl/csr_access_port.sv
rtl/exception_state.sv
rtl/software_regs.sv
rtl/timer_unit.sv
rtl/interrupt_ctrl.sv
rtl/csr_unit.sv
tests/csr_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
        -f vlog.f \
        --top-module csr_unit_tb \
        -o csr_unit_tb

output=$(./obj_dir/csr_unit_tb)
echo "$output"

echo "$output" | grep -q "Simulation PASSED"
